// File: hdl/uartRegPkg.sv
// Register map and bit layout of the SC2661-style UART
// Async 8N1 only, the mode register is stored but never decoded
// Status bits 3 (parity) and 5 (framing) have no position and read zero
// Echo mode code is kept for the map only, the RTL treats it as normal

package uartRegPkg;

  // ----------------------------------------
  // Register addresses
  // ----------------------------------------
  localparam logic [1:0] regAddrThr     = 2'd0;  // THR on write, RHR on read
  localparam logic [1:0] regAddrStatus  = 2'd1;  // Status on read, SYN/DLE write ignored
  localparam logic [1:0] regAddrMode    = 2'd2;
  localparam logic [1:0] regAddrCommand = 2'd3;

  typedef logic [7:0] byteT;  // Bus and character width

  // Command register, read back as a byte and decoded as control fields
  typedef union packed {
    byteT raw;
    struct packed {
      logic [1:0] operatingMode;  // CR7:6
      logic       rtsLow;         // CR5 forces RTS_n low
      logic       errorReset;     // CR4 clears overrun on write
      logic       breakUnused;    // CR3, stored only
      logic       rxEnable;       // CR2
      logic       dtrLow;         // CR1 forces DTR_n low
      logic       txEnable;       // CR0
    } fields;
  } cmdWordU;

  // Operating modes in CR7:6
  localparam logic [1:0] opModeNormal     = 2'b00;
  localparam logic [1:0] opModeEcho       = 2'b01;
  localparam logic [1:0] opModeLocalLoop  = 2'b10;  // TXD looped into receiver
  localparam logic [1:0] opModeRemoteLoop = 2'b11;  // Received chars retransmitted

  // ----------------------------------------
  // Status register bit positions
  // ----------------------------------------
  localparam int srTxRdy   = 0;  // THR empty
  localparam int srRxRdy   = 1;  // RHR full
  localparam int srChange  = 2;  // TX empty or DCD/DSR change
  localparam int srOverrun = 4;
  localparam int srDcd     = 6;  // Follows inverted DCD_n
  localparam int srDsr     = 7;  // Follows inverted DSR_n

endpackage

// File: hdl/uartLinePkg.sv
// Serial framing constants, fixed 8N1 at 16 BRCLK cycles per bit
// No baud rate divider, BRCLK itself must run at 16x the bit rate
// Counter widths assume bitCycles stays at or below 32

package uartLinePkg;

  // ----------------------------------------
  // Frame format
  // ----------------------------------------
  localparam int dataBits      = 8;              // Data bits, LSB first
  localparam int bitCycles     = 16;             // BRCLK cycles per bit
  localparam int halfBitCycles = bitCycles / 2;  // Start edge to mid start bit

  // Bit timer, counts BRCLK cycles inside one bit
  typedef logic [4:0] bitCountT;

  // Index of the current data bit
  typedef logic [2:0] bitIndexT;

endpackage

// File: hdl/uartRegisterFile.sv
// CPU side register block of the SC2661-style UART
// Bus is sampled on BRCLK edges while ceN is low; readN high writes, low reads
// A read needs ceN low for two cycles, dataOut is valid in the second
// Writes to address 1 (SYN/DLE) are ignored, the mode register is plain storage
// A THR write while the transmitter is busy is lost, poll TXDRDY_n first
// Error reset acts on the command byte being written

`timescale 1ns/100ps

module uartRegisterFile (
  input  logic                BRCLK,
  input  logic                s_reset,
  input  logic [1:0]          address,
  input  uartRegPkg::byteT    dataIn,
  input  logic                ceN,
  input  logic                readN,
  input  logic                dcdN,
  input  logic                dsrN,
  input  logic                txDone,      // One cycle after stop bit
  input  logic                rxStart,     // Start bit confirmed
  input  logic                rxDone,      // Character in rxData
  input  uartRegPkg::byteT    rxData,
  output uartRegPkg::byteT    dataOut,
  output uartRegPkg::cmdWordU cmdWord,
  output logic                txLoad,      // One-cycle load pulse
  output uartRegPkg::byteT    txLoadData,
  output logic                rxRdyN,
  output logic                txRdyN,
  output logic                txEmtN
);

  import uartRegPkg::*;

  byteT    modeReg;
  byteT    statusReg;
  byteT    readReg;      // Latched on the read edge
  cmdWordU newCmd;       // Command byte on the bus
  logic    busWrite;
  logic    busRead;
  logic    thrWrite;
  logic    remoteLoop;
  logic    modemChange;

  // ----------------------------------------
  // Bus decode
  // ----------------------------------------
  assign busWrite   = !ceN && readN;
  assign busRead    = !ceN && !readN;
  assign thrWrite   = busWrite && (address == regAddrThr);
  assign newCmd     = cmdWordU'(dataIn);
  assign remoteLoop = cmdWord.fields.operatingMode == opModeRemoteLoop;

  // Stored SR6/SR7 still equal to the pin means the pin just moved
  assign modemChange = (statusReg[srDcd] == dcdN) || (statusReg[srDsr] == dsrN);

  // Mode, command and status registers
  always_ff @(posedge BRCLK) begin
    if (!s_reset) begin
      modeReg            <= '0;
      cmdWord.raw        <= '0;
      statusReg          <= '0;
      statusReg[srTxRdy] <= 1'b1;  // THR empty out of reset
    end else begin
      if (busWrite) begin
        case (address)
          regAddrThr:  statusReg[srTxRdy] <= 1'b0;  // THR now full
          regAddrMode: modeReg <= dataIn;
          regAddrCommand: begin
            cmdWord <= newCmd;
            if (!newCmd.fields.rxEnable)
              statusReg[srRxRdy] <= 1'b0;     // Disabling RX drops the char
            if (newCmd.fields.errorReset)
              statusReg[srOverrun] <= 1'b0;
          end
          default: ;                          // SYN/DLE write, not supported
        endcase
      end else if (busRead) begin
        case (address)
          regAddrThr:    statusReg[srRxRdy] <= 1'b0;   // RHR taken
          regAddrStatus: statusReg[srChange] <= 1'b0;  // Status read acks SR2
          default: ;
        endcase
      end

      // Modem lines, stored inverted
      statusReg[srDcd] <= !dcdN;
      statusReg[srDsr] <= !dsrN;
      if ((cmdWord.fields.rxEnable || cmdWord.fields.txEnable) && modemChange)
        statusReg[srChange] <= 1'b1;

      // Transmitter events win over bus clears
      if (txDone || !cmdWord.fields.txEnable)
        statusReg[srTxRdy] <= 1'b1;
      if (txDone)
        statusReg[srChange] <= 1'b1;          // Shift register empty

      // Receiver events
      if (rxStart) begin
        if (statusReg[srRxRdy])
          statusReg[srOverrun] <= 1'b1;       // Previous char never read
        statusReg[srRxRdy] <= 1'b0;
      end
      if (rxDone)
        statusReg[srRxRdy] <= 1'b1;
    end
  end

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  always_ff @(posedge BRCLK) begin
    if (busRead) begin
      case (address)
        regAddrThr:     readReg <= rxData;
        regAddrStatus:  readReg <= statusReg;
        regAddrMode:    readReg <= modeReg;
        regAddrCommand: readReg <= cmdWord.raw;
      endcase
    end
  end

  assign dataOut = busRead ? readReg : '0;

  // Transmit loads, host writes first, then remote loopback chars
  always_ff @(posedge BRCLK) begin
    if (!s_reset)
      txLoad <= 1'b0;
    else
      txLoad <= thrWrite || (rxDone && remoteLoop);
  end

  always_ff @(posedge BRCLK) begin
    if (thrWrite)
      txLoadData <= dataIn;
    else if (rxDone)
      txLoadData <= rxData;   // Only used when remoteLoop pulses txLoad
  end

  // Ready pins, valid only while the side is enabled
  assign txRdyN = cmdWord.fields.txEnable ? !statusReg[srTxRdy] : 1'b1;
  assign rxRdyN = cmdWord.fields.rxEnable ? !statusReg[srRxRdy] : 1'b1;
  assign txEmtN = !statusReg[srChange];

endmodule

// File: hdl/uartTransmitter.sv
// Serializer, start bit, eight data bits LSB first, one stop bit
// Each bit lasts exactly bitCycles BRCLK cycles, TXD is a flop output
// A load is taken only in idle, a load while busy is dropped
// Clearing txEnable idles the line on the next cycle and drops the char

`timescale 1ns/100ps

module uartTransmitter (
  input  logic             BRCLK,
  input  logic             s_reset,
  input  logic             txEnable,
  input  logic             txLoad,
  input  uartRegPkg::byteT txLoadData,
  output logic             txd,
  output logic             txDone
);

  import uartRegPkg::*;
  import uartLinePkg::*;

  localparam logic [2:0] stIdle  = 3'd0;
  localparam logic [2:0] stStart = 3'd1;
  localparam logic [2:0] stData  = 3'd2;
  localparam logic [2:0] stStop  = 3'd3;
  localparam logic [2:0] stDone  = 3'd4;

  logic [2:0] state;
  bitCountT   bitTimer;
  bitIndexT   bitIndex;
  byteT       holdReg;    // Character being sent
  logic       bitEnd;

  assign bitEnd = bitTimer == bitCountT'(bitCycles - 1);
  assign txDone = state == stDone;  // Single cycle, done always returns to idle

  // ----------------------------------------
  // Frame FSM
  // ----------------------------------------
  always_ff @(posedge BRCLK) begin
    if (!s_reset) begin
      state    <= stIdle;
      bitTimer <= '0;
      bitIndex <= '0;
      txd      <= 1'b1;
    end else if (!txEnable) begin
      state    <= stIdle;
      bitTimer <= '0;
      txd      <= 1'b1;     // Mark state while disabled
    end else begin
      bitTimer <= bitEnd ? '0 : bitTimer + 1'b1;
      case (state)
        stIdle: begin
          bitTimer <= '0;
          if (txLoad) begin
            state <= stStart;
            txd   <= 1'b0;  // Start bit
          end
        end
        stStart: begin
          if (bitEnd) begin
            state    <= stData;
            bitIndex <= '0;
            txd      <= holdReg[0];
          end
        end
        stData: begin
          if (bitEnd) begin
            if (bitIndex == bitIndexT'(dataBits - 1)) begin
              state <= stStop;
              txd   <= 1'b1;  // Stop bit
            end else begin
              bitIndex <= bitIndex + 1'b1;
              txd      <= holdReg[bitIndex + 1'b1];
            end
          end
        end
        stStop:  if (bitEnd) state <= stDone;
        default: state <= stIdle;  // stDone
      endcase
    end
  end

  // Character capture on an accepted load
  always_ff @(posedge BRCLK) begin
    if (txEnable && txLoad && state == stIdle)
      holdReg <= txLoadData;
  end

endmodule

// File: hdl/uartReceiver.sv
// Async receiver, 8N1 at bitCycles BRCLK cycles per bit
// rxd must already be synchronous to BRCLK, there is no synchronizer
// Start bit is checked again at its middle, a short low pulse is ignored
// Data bits are sampled once at mid bit, no majority vote
// Stop bit level is not checked, framing errors are not reported

`timescale 1ns/100ps

module uartReceiver (
  input  logic             BRCLK,
  input  logic             s_reset,
  input  logic             rxEnable,
  input  logic             localLoop,   // Take TXD instead of RXD
  input  logic             rxd,
  input  logic             txd,
  output logic             rxStart,     // Pulse at confirmed start bit
  output logic             rxDone,      // Pulse with new rxData
  output uartRegPkg::byteT rxData
);

  import uartRegPkg::*;
  import uartLinePkg::*;

  localparam logic [1:0] stIdle  = 2'd0;
  localparam logic [1:0] stStart = 2'd1;
  localparam logic [1:0] stData  = 2'd2;
  localparam logic [1:0] stStop  = 2'd3;

  logic [1:0] state;
  bitCountT   bitTimer;
  bitIndexT   bitIndex;
  byteT       shiftReg;   // Assembles the character, LSB arrives first
  logic       rxIn;
  logic       bitEnd;

  assign rxIn   = localLoop ? txd : rxd;
  assign bitEnd = bitTimer == bitCountT'(bitCycles - 1);

  // ----------------------------------------
  // Frame FSM
  // ----------------------------------------
  always_ff @(posedge BRCLK) begin
    if (!s_reset) begin
      state    <= stIdle;
      bitTimer <= '0;
      bitIndex <= '0;
      rxStart  <= 1'b0;
      rxDone   <= 1'b0;
    end else begin
      rxStart <= 1'b0;
      rxDone  <= 1'b0;
      if (!rxEnable) begin
        state    <= stIdle;
        bitTimer <= '0;
      end else begin
        bitTimer <= bitTimer + 1'b1;
        case (state)
          stIdle: begin
            bitTimer <= '0;
            if (!rxIn)
              state <= stStart;             // Falling edge seen
          end
          stStart: begin
            if (bitTimer == bitCountT'(halfBitCycles - 1)) begin
              bitTimer <= '0;
              bitIndex <= '0;
              if (rxIn) begin
                state <= stIdle;            // Glitch, line back high
              end else begin
                state   <= stData;
                rxStart <= 1'b1;
              end
            end
          end
          stData: begin
            if (bitEnd) begin               // Mid data bit
              bitTimer <= '0;
              bitIndex <= bitIndex + 1'b1;
              if (bitIndex == bitIndexT'(dataBits - 1))
                state <= stStop;
            end
          end
          default: begin                    // stStop, wait out the stop bit
            if (bitEnd) begin
              state  <= stIdle;
              rxDone <= 1'b1;
            end
          end
        endcase
      end
    end
  end

  // Shift in from the top, holding register loads with rxDone
  always_ff @(posedge BRCLK) begin
    if (rxEnable && state == stData && bitEnd)
      shiftReg <= {rxIn, shiftReg[7:1]};
    if (rxEnable && state == stStop && bitEnd)
      rxData <= shiftReg;
  end

endmodule

// File: hdl/sc2661Uart.sv
// SC2661-style async UART, fixed 8N1 at 16 BRCLK cycles per bit
// No sync mode, no RXC/TXC, CTS ignored, no break or parity
// Serial pins and bus are synchronous to BRCLK
// Reset is synchronous and active low on s_reset

`timescale 1ns/100ps

module sc2661Uart (
  input  logic             BRCLK,
  input  logic             s_reset,
  input  logic [1:0]       address,
  input  uartRegPkg::byteT dataIn,
  input  logic             ceN,
  input  logic             readN,
  input  logic             dcdN,
  input  logic             dsrN,
  input  logic             rxd,
  output uartRegPkg::byteT dataOut,
  output logic             txd,
  output logic             dtrN,
  output logic             rtsN,
  output logic             rxRdyN,
  output logic             txRdyN,
  output logic             txEmtN
);

  import uartRegPkg::*;

  cmdWordU cmdWord;
  logic    txLoad;
  logic    txDone;
  logic    rxStart;
  logic    rxDone;
  logic    localLoop;
  byteT    txLoadData;
  byteT    rxData;

  // ----------------------------------------
  // Command decode
  // ----------------------------------------
  assign localLoop = cmdWord.fields.operatingMode == opModeLocalLoop;
  assign dtrN      = !cmdWord.fields.dtrLow;
  assign rtsN      = !cmdWord.fields.rtsLow;

  uartRegisterFile i_regFile (
    .BRCLK      (BRCLK),
    .s_reset    (s_reset),
    .address    (address),
    .dataIn     (dataIn),
    .ceN        (ceN),
    .readN      (readN),
    .dcdN       (dcdN),
    .dsrN       (dsrN),
    .txDone     (txDone),
    .rxStart    (rxStart),
    .rxDone     (rxDone),
    .rxData     (rxData),
    .dataOut    (dataOut),
    .cmdWord    (cmdWord),
    .txLoad     (txLoad),
    .txLoadData (txLoadData),
    .rxRdyN     (rxRdyN),
    .txRdyN     (txRdyN),
    .txEmtN     (txEmtN)
  );

  uartTransmitter i_transmitter (
    .BRCLK      (BRCLK),
    .s_reset    (s_reset),
    .txEnable   (cmdWord.fields.txEnable),
    .txLoad     (txLoad),
    .txLoadData (txLoadData),
    .txd        (txd),
    .txDone     (txDone)
  );

  uartReceiver i_receiver (
    .BRCLK     (BRCLK),
    .s_reset   (s_reset),
    .rxEnable  (cmdWord.fields.rxEnable),
    .localLoop (localLoop),
    .rxd       (rxd),
    .txd       (txd),           // Loopback source
    .rxStart   (rxStart),
    .rxDone    (rxDone),
    .rxData    (rxData)
  );

endmodule

// File: dv/sc2661UartProperties.sv
// Port rules of the UART top level, attached by bind
// Checks run on every BRCLK edge, reset included
// failCount is read by the testbench for its closing result

`timescale 1ns/100ps

module sc2661UartProperties (
  input logic             BRCLK,
  input logic             s_reset,
  input logic             ceN,
  input logic             readN,
  input logic             txd,
  input logic             rxRdyN,
  input logic             txRdyN,
  input uartRegPkg::byteT dataOut
);

  int failCount = 0;  // Failed assertions so far

  // ----------------------------------------
  // Bus and reset rules
  // ----------------------------------------
  dataOutIdle: assert property (@(posedge BRCLK) (ceN || readN) |-> dataOut == '0)
    else begin
      failCount++;
      $error("dataOut is not zero outside a read");
    end

  txdAfterReset: assert property (@(posedge BRCLK) !s_reset |=> txd)
    else begin
      failCount++;
      $error("txd is not high after reset");
    end

  // Both sides disabled out of reset
  readyAfterReset: assert property (@(posedge BRCLK) !s_reset |=> rxRdyN && txRdyN)
    else begin
      failCount++;
      $error("rxRdyN or txRdyN is low after reset");
    end

endmodule

bind sc2661Uart sc2661UartProperties i_props (
  .BRCLK   (BRCLK),
  .s_reset (s_reset),
  .ceN     (ceN),
  .readN   (readN),
  .txd     (txd),
  .rxRdyN  (rxRdyN),
  .txRdyN  (txRdyN),
  .dataOut (dataOut)
);

// File: dv/sc2661UartTb.sv
// Directed testbench of the SC2661-style UART
// Inputs change 1 ns after the rising BRCLK edge and outputs are sampled there too
// Serial frames are 8N1 at bitCycles BRCLK cycles per bit on both lines
// Data bytes come from an LCG, so a run is always the same

`timescale 1ns/100ps

module sc2661UartTb;

  import uartRegPkg::*;
  import uartLinePkg::*;

  logic       BRCLK;
  logic       s_reset;
  logic [1:0] address;
  byteT       dataIn;
  logic       ceN;
  logic       readN;
  logic       dcdN;
  logic       dsrN;
  logic       rxd;
  byteT       dataOut;
  logic       txd;
  logic       dtrN;
  logic       rtsN;
  logic       rxRdyN;
  logic       txRdyN;
  logic       txEmtN;

  int          checkCount   = 0;
  int          errorCount   = 0;
  int          timeoutCount = 0;
  logic [31:0] lcgState     = 32'hd5562024;

  sc2661Uart i_sc2661Uart (
    .BRCLK   (BRCLK),
    .s_reset (s_reset),
    .address (address),
    .dataIn  (dataIn),
    .ceN     (ceN),
    .readN   (readN),
    .dcdN    (dcdN),
    .dsrN    (dsrN),
    .rxd     (rxd),
    .dataOut (dataOut),
    .txd     (txd),
    .dtrN    (dtrN),
    .rtsN    (rtsN),
    .rxRdyN  (rxRdyN),
    .txRdyN  (txRdyN),
    .txEmtN  (txEmtN)
  );

  initial begin
    BRCLK = 1'b0;
    forever #2 BRCLK = ~BRCLK;  // 4 ns period
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic tick();
    @(posedge BRCLK);
    #1;                         // Drive and sample point
  endtask

  function automatic byteT nextByte();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[23:16];     // Upper bits are the better ones
  endfunction

  task automatic checkByte(input string testName, input byteT expected, input byteT actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("FAILED %s expected %h actual %h", testName, expected, actual);
    end
  endtask

  task automatic checkBit(input string testName, input logic expected, input logic actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("FAILED %s expected %b actual %b", testName, expected, actual);
    end
  endtask

  task automatic endRun();
    $display("Checks %0d, check errors %0d, timeouts %0d, assertion errors %0d",
             checkCount, errorCount, timeoutCount, i_sc2661Uart.i_props.failCount);
    if (errorCount == 0 && timeoutCount == 0 && i_sc2661Uart.i_props.failCount == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  endtask

  function automatic logic pinLevel(input string pinName);
    case (pinName)
      "txd":    return txd;
      "rxRdyN": return rxRdyN;
      "txRdyN": return txRdyN;
      "txEmtN": return txEmtN;
      default:  return 1'bx;
    endcase
  endfunction

  // Poll one output until it reads low
  task automatic waitForLow(input string pinName, input int limit);
    int cycles;
    cycles = 0;
    while (pinLevel(pinName) !== 1'b0 && cycles < limit) begin
      tick();
      cycles++;
    end
    if (cycles >= limit) begin
      timeoutCount++;
      $display("Timeout, %s did not go low within %0d cycles", pinName, limit);
    end
  endtask

  // ----------------------------------------
  // Bus and serial line tasks
  // ----------------------------------------
  task automatic busWrite(input logic [1:0] addr, input byteT data);
    ceN     = 1'b0;
    readN   = 1'b1;
    address = addr;
    dataIn  = data;
    tick();                     // Sampled on this edge
    ceN     = 1'b1;
  endtask

  task automatic busRead(input logic [1:0] addr, output byteT data);
    ceN     = 1'b0;
    readN   = 1'b0;
    address = addr;
    tick();                     // Register latched
    data    = dataOut;          // Valid in the second cycle
    tick();
    ceN     = 1'b1;
    readN   = 1'b1;
  endtask

  task automatic sendSerial(input byteT data);
    bitIndexT idx;
    idx = '0;
    rxd = 1'b0;                 // Start bit
    repeat (bitCycles) tick();
    repeat (dataBits) begin
      rxd = data[idx];
      idx++;
      repeat (bitCycles) tick();
    end
    rxd = 1'b1;                 // Stop bit
    repeat (bitCycles) tick();
  endtask

  // Finds the start edge, then samples each bit in its middle
  task automatic captureSerial(output byteT data);
    bitIndexT idx;
    idx = '0;
    waitForLow("txd", 500);
    repeat (halfBitCycles) tick();
    checkBit("start bit level", 1'b0, txd);
    repeat (dataBits) begin
      repeat (bitCycles) tick();
      data[idx] = txd;
      idx++;
    end
    repeat (bitCycles) tick();
    checkBit("stop bit level", 1'b1, txd);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    byteT sent;
    byteT got;
    byteT status;
    s_reset = 1'b0;
    ceN     = 1'b1;
    readN   = 1'b1;
    address = '0;
    dataIn  = '0;
    dcdN    = 1'b1;
    dsrN    = 1'b1;
    rxd     = 1'b1;                       // Line idle
    repeat (10) tick();
    s_reset = 1'b1;
    tick();

    checkBit("reset txd", 1'b1, txd);
    checkBit("reset dtrN", 1'b1, dtrN);
    checkBit("reset rtsN", 1'b1, rtsN);
    checkBit("reset rxRdyN", 1'b1, rxRdyN);
    checkBit("reset txRdyN", 1'b1, txRdyN);
    checkBit("reset txEmtN", 1'b1, txEmtN);
    checkByte("reset dataOut", 8'h00, dataOut);

    // Register access and modem outputs
    sent = nextByte();
    busWrite(regAddrMode, sent);
    busRead(regAddrMode, got);
    checkByte("mode readback", sent, got);
    busWrite(regAddrCommand, 8'h22);      // rtsLow and dtrLow
    busRead(regAddrCommand, got);
    checkByte("command readback", 8'h22, got);
    checkBit("dtrN from command", 1'b0, dtrN);
    checkBit("rtsN from command", 1'b0, rtsN);

    // Transmit
    busWrite(regAddrCommand, 8'h01);
    sent = nextByte();
    busWrite(regAddrThr, sent);
    captureSerial(got);
    checkByte("transmit byte", sent, got);
    waitForLow("txRdyN", 40);
    checkBit("txEmtN after frame", 1'b0, txEmtN);
    busRead(regAddrStatus, status);
    checkBit("SR0 after frame", 1'b1, status[srTxRdy]);
    checkBit("SR2 after frame", 1'b1, status[srChange]);

    // Receive
    busWrite(regAddrCommand, 8'h04);
    sent = nextByte();
    sendSerial(sent);
    waitForLow("rxRdyN", 40);
    busRead(regAddrThr, got);
    checkByte("receive byte", sent, got);
    checkBit("rxRdyN after RHR read", 1'b1, rxRdyN);

    // Overrun with the second char left unread
    sendSerial(nextByte());
    sendSerial(nextByte());
    waitForLow("rxRdyN", 40);
    busRead(regAddrStatus, status);
    checkBit("SR4 after overrun", 1'b1, status[srOverrun]);
    busWrite(regAddrCommand, 8'h14);      // errorReset with RX kept on
    busRead(regAddrStatus, status);
    checkBit("SR4 after error reset", 1'b0, status[srOverrun]);
    busRead(regAddrThr, got);             // Empty the RHR

    // Local loopback
    busWrite(regAddrCommand, 8'h85);
    sent = nextByte();
    busWrite(regAddrThr, sent);
    waitForLow("rxRdyN", 400);
    busRead(regAddrThr, got);
    checkByte("local loopback byte", sent, got);
    waitForLow("txRdyN", 40);

    // Remote loopback
    busWrite(regAddrCommand, 8'hC5);
    busRead(regAddrStatus, status);       // Clears SR2 left by the local frame
    sent = nextByte();
    fork
      sendSerial(sent);
      captureSerial(got);
    join
    checkByte("remote loopback byte", sent, got);
    waitForLow("txEmtN", 40);             // Echo frame finished
    busRead(regAddrStatus, status);       // Acks SR2 from the echo
    checkBit("txEmtN after status read", 1'b1, txEmtN);

    // DCD change
    dcdN = 1'b0;
    waitForLow("txEmtN", 10);
    busRead(regAddrStatus, status);
    checkBit("SR2 after DCD change", 1'b1, status[srChange]);
    checkBit("SR6 follows DCD", 1'b1, status[srDcd]);
    checkBit("txEmtN after change ack", 1'b1, txEmtN);

    endRun();
  end

endmodule

// File: sc2661Uart.f
hdl/uartRegPkg.sv
hdl/uartLinePkg.sv
hdl/uartRegisterFile.sv
hdl/uartTransmitter.sv
hdl/uartReceiver.sv
hdl/sc2661Uart.sv
dv/sc2661UartProperties.sv
dv/sc2661UartTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = sc2661UartTb
FILELIST  = sc2661Uart.f
OBJDIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)
